// ==== Makefile ====
# Verilator build, run and lint for the shooter playfield logic

VERILATOR ?= verilator
TOP       ?= shooter_tb
FILELIST  ?= shooter_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/shooter_tb.sv ====
// ####################
// Testbench for the playfield logic, APB tasks and a table of shots
// ####################
`timescale 1ns/1ps
`default_nettype none

module shooter_tb;
   import shooter_pkg::*;

   localparam int STEP_PERIOD = 8;
   localparam int NUM_ROWS    = 6;
   // A shot needs well under 16 steps, the extra rows cover the register checks
   localparam int TIMEOUT_CYCLES = (NUM_ROWS + 6) * 16 * STEP_PERIOD;
   localparam apb_addr_t ADDR_UNMAPPED = 5'h14;
   localparam apb_data_t PARKED_STATUS = {16'd0, 4'd0, PARK_ROW, 3'd0, PARK_COL};

   logic      clk_36MHz = 1'b0;
   logic      rst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   int        error_count = 0;
   int        check_count = 0;
   int        cycle_count = 0;
   integer    seed = 76;

   // Per row: value written to SHIP first, aim at the invader, expected score change
   apb_data_t table_ship [NUM_ROWS] = '{32'h0000_0025, 32'hFFFF_FFE3, 32'h0000_0007,
                                        32'h0000_011F, 32'h0000_0040, 32'h0000_0C0A};
   bit        table_aim [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
   int        table_delta [NUM_ROWS] = '{1, 0, 1, 1, 0, 1};

   shooter_top #(
      .STEP_CYCLES (STEP_PERIOD)
   ) dut_i (
      .i_clk_36MHz (clk_36MHz),
      .i_rst_n     (rst_n),
      .i_psel      (psel),
      .i_penable   (penable),
      .i_pwrite    (pwrite),
      .i_paddr     (paddr),
      .i_pwdata    (pwdata),
      .o_prdata    (prdata),
      .o_pready    (pready),
      .o_pslverr   (pslverr)
   );

   always #50 clk_36MHz = ~clk_36MHz;

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk_36MHz);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the bullet never parked or the bus hung",
               cycle_count);
      $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
      $display("tests failed");
      $finish;
   end

   task automatic check_value(input string name, input apb_data_t got,
                              input apb_data_t exp);
      check_count++;
      assert (got == exp) else begin
         error_count++;
         $display("Fail at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      @(posedge clk_36MHz);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk_36MHz);
      #1;
      penable = 1'b1;
      // Read data and the error flag are combinational, so mid cycle is stable
      #40;
      rdata = prdata;
      err   = pslverr;
      check_value("o_pready", 32'(pready), 32'd1);
      @(posedge clk_36MHz);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      apb_data_t ignored;
      apb_xfer(1'b1, addr, data, ignored, err);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      apb_xfer(1'b0, addr, 32'd0, data, err);
   endtask

   // Polls STATUS from the first poll after a shot until the bullet parks
   task automatic fly_and_park(input col_t exp_col);
      apb_data_t status;
      logic      err;
      row_t      prev_row;
      row_t      cur_row;
      apb_read(ADDR_STATUS, status, err);
      check_value("STATUS active", 32'(status[STATUS_ACTIVE_BIT]), 32'd1);
      check_value("STATUS column", 32'(status[4:0]), 32'(exp_col));
      prev_row = status[11:8];
      check_count++;
      assert (prev_row <= LAUNCH_ROW) else begin
         error_count++;
         $display("Fail at %0t: STATUS row got %0d, expected at most %0d",
                  $time, prev_row, LAUNCH_ROW);
      end
      while (status[STATUS_ACTIVE_BIT]) begin
         apb_read(ADDR_STATUS, status, err);
         cur_row = status[11:8];
         if (status[STATUS_ACTIVE_BIT]) begin
            check_value("STATUS column", 32'(status[4:0]), 32'(exp_col));
            check_count++;
            assert (cur_row <= prev_row) else begin
               error_count++;
               $display("Fail at %0t: STATUS row got %0d, expected at most %0d",
                        $time, cur_row, prev_row);
            end
            prev_row = cur_row;
         end
      end
      check_value("STATUS", status, PARKED_STATUS);
   endtask

   initial begin
      apb_data_t rdata;
      logic      err;
      col_t      inv_col;
      col_t      ship_col;
      col_t      next_col;
      int        exp_score;
      int        moves;
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      exp_score = 0;
      moves     = 0;
      repeat (16) @(posedge clk_36MHz);
      #1;
      rst_n = 1'b1;

      // INVADER goes first, before the first step can move it
      apb_read(ADDR_INVADER, rdata, err);
      check_value("INVADER", rdata, 32'd0);
      check_value("o_pslverr", 32'(err), 32'd0);
      apb_read(ADDR_SCORE, rdata, err);
      check_value("SCORE", rdata, 32'd0);
      apb_read(ADDR_STATUS, rdata, err);
      check_value("STATUS", rdata, PARKED_STATUS);
      apb_read(ADDR_UNMAPPED, rdata, err);
      check_value("o_pslverr", 32'(err), 32'd1);

      apb_write(ADDR_SHIP, 32'hFFFF_FFF5, err);
      apb_read(ADDR_SHIP, rdata, err);
      check_value("SHIP", rdata, 32'h0000_0015);
      apb_write(ADDR_SCORE, 32'h0000_00AA, err);
      check_value("o_pslverr", 32'(err), 32'd1);
      apb_read(ADDR_SCORE, rdata, err);
      check_value("SCORE", rdata, 32'd0);

      // Freeze the invader, then shoot again while the first bullet climbs
      apb_write(ADDR_CTRL, 32'h2, err);
      apb_read(ADDR_INVADER, rdata, err);
      inv_col  = rdata[4:0];
      ship_col = inv_col + 5'd5;
      next_col = ship_col + 5'd9;
      apb_write(ADDR_SHIP, 32'(ship_col), err);
      apb_write(ADDR_CTRL, 32'h3, err);
      apb_write(ADDR_SHIP, 32'(next_col), err);
      apb_write(ADDR_CTRL, 32'h3, err);
      fly_and_park(ship_col);
      apb_read(ADDR_SCORE, rdata, err);
      check_value("SCORE", rdata, 32'd0);

      for (int i = 0; i < NUM_ROWS; i++) begin
         apb_write(ADDR_CTRL, 32'h2, err);
         apb_write(ADDR_SHIP, table_ship[i], err);
         apb_read(ADDR_SHIP, rdata, err);
         check_value("SHIP", rdata, table_ship[i] & 32'h1F);
         apb_read(ADDR_INVADER, rdata, err);
         inv_col = rdata[4:0];
         if (table_aim[i]) begin
            ship_col = inv_col;
         end else begin
            ship_col = col_t'($random(seed));
            if (ship_col == inv_col) begin
               ship_col = ship_col + 5'd1;
            end
         end
         apb_write(ADDR_SHIP, 32'(ship_col), err);
         apb_write(ADDR_CTRL, 32'h3, err);
         fly_and_park(ship_col);
         exp_score = exp_score + table_delta[i];
         apb_read(ADDR_SCORE, rdata, err);
         check_value("SCORE", rdata, 32'(exp_score));
         apb_read(ADDR_INVADER, rdata, err);
         check_value("INVADER", rdata, table_aim[i] ? 32'd0 : 32'(inv_col));
      end

      // With pause cleared the invader creeps one column at a time
      apb_write(ADDR_CTRL, 32'h0, err);
      apb_read(ADDR_INVADER, rdata, err);
      inv_col = rdata[4:0];
      repeat (40) begin
         apb_read(ADDR_INVADER, rdata, err);
         next_col = rdata[4:0];
         check_count++;
         assert (next_col == inv_col || next_col == inv_col + 5'd1) else begin
            error_count++;
            $display("Fail at %0t: INVADER got %0d, expected %0d or one column on",
                     $time, next_col, inv_col);
         end
         if (next_col != inv_col) begin
            moves++;
         end
         inv_col = next_col;
      end
      check_count++;
      assert (moves > 0) else begin
         error_count++;
         $display("The invader never moved while pause was cleared");
      end

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/bullet.sv ====
// ####################
// Bullet FSM, launch from the ship and climb one row per step
// ####################
`timescale 1ns/1ps
`default_nettype none

module bullet (
   input  wire                   i_clk_36MHz,
   input  wire                   i_rst_n,
   input  wire                   i_shoot,
   input  wire                   i_hit,
   input  wire                   i_step,
   input  wire shooter_pkg::col_t i_ship_x,
   output shooter_pkg::col_t      o_bullet_x,
   output shooter_pkg::row_t      o_bullet_y,
   output logic                  o_active
);
   import shooter_pkg::*;

   bullet_state_t state_q;
   bullet_state_t state_d;
   col_t          x_d;
   row_t          y_d;

   always_comb begin
      state_d = state_q;
      x_d     = o_bullet_x;
      y_d     = o_bullet_y;
      case (state_q)
         BULLET_IDLE: begin
            // A shot only starts from idle, so extra shoots in flight are dropped
            if (i_shoot) begin
               x_d     = i_ship_x;
               y_d     = LAUNCH_ROW;
               state_d = BULLET_LAUNCH;
            end
         end
         BULLET_LAUNCH: begin
            if (i_hit) begin
               x_d     = PARK_COL;
               y_d     = PARK_ROW;
               state_d = BULLET_IDLE;
            end else begin
               state_d = BULLET_MOVING;
            end
         end
         BULLET_MOVING: begin
            if (i_hit) begin
               x_d     = PARK_COL;
               y_d     = PARK_ROW;
               state_d = BULLET_IDLE;
            end else if (i_step && o_bullet_y != '0) begin
               y_d = o_bullet_y - 1'b1;
            end else if (o_bullet_y == '0) begin
               // Top of the matrix reached
               x_d     = PARK_COL;
               y_d     = PARK_ROW;
               state_d = BULLET_IDLE;
            end
         end
         default: begin
            x_d     = PARK_COL;
            y_d     = PARK_ROW;
            state_d = BULLET_IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_rst_n) begin
         state_q    <= BULLET_IDLE;
         o_bullet_x <= PARK_COL;
         o_bullet_y <= PARK_ROW;
      end else begin
         state_q    <= state_d;
         o_bullet_x <= x_d;
         o_bullet_y <= y_d;
      end
   end

   assign o_active = (state_q != BULLET_IDLE);

   // The row never leaves the playfield or the park position
   assert property (@(posedge i_clk_36MHz) disable iff (!i_rst_n) o_bullet_y <= PARK_ROW)
      else $error("bullet row %0d beyond park row", o_bullet_y);

endmodule

`default_nettype wire

// ==== logic/game_regs_apb.sv ====
// ####################
// APB register block for control, ship position and game status
// ####################
`timescale 1ns/1ps
`default_nettype none

module game_regs_apb (
   input  wire                        i_clk_36MHz,
   input  wire                        i_rst_n,
   input  wire                        i_psel,
   input  wire                        i_penable,
   input  wire                        i_pwrite,
   input  wire shooter_pkg::apb_addr_t i_paddr,
   input  wire shooter_pkg::apb_data_t i_pwdata,
   output shooter_pkg::apb_data_t      o_prdata,
   output logic                       o_pready,
   output logic                       o_pslverr,
   input  wire shooter_pkg::col_t      i_bullet_x,
   input  wire shooter_pkg::row_t      i_bullet_y,
   input  wire                        i_bullet_active,
   input  wire shooter_pkg::col_t      i_invader_x,
   input  wire shooter_pkg::score_t    i_score,
   output logic                       o_shoot,
   output logic                       o_pause,
   output shooter_pkg::col_t           o_ship_x
);
   import shooter_pkg::*;

   logic access;
   logic addr_ok;
   logic addr_ro;
   logic wr_ctrl;
   logic wr_ship;

   // Registers act only in the access phase
   assign access  = i_psel & i_penable;
   assign wr_ctrl = access & i_pwrite & (i_paddr == ADDR_CTRL);
   assign wr_ship = access & i_pwrite & (i_paddr == ADDR_SHIP);

   always_comb begin
      addr_ok  = 1'b1;
      addr_ro  = 1'b0;
      o_prdata = '0;
      case (i_paddr)
         ADDR_CTRL: begin
            o_prdata = '0;
         end
         ADDR_SHIP: begin
            o_prdata = {27'd0, o_ship_x};
         end
         ADDR_STATUS: begin
            addr_ro  = 1'b1;
            o_prdata = {15'd0, i_bullet_active, 4'd0, i_bullet_y, 3'd0, i_bullet_x};
         end
         ADDR_SCORE: begin
            addr_ro  = 1'b1;
            o_prdata = {24'd0, i_score};
         end
         ADDR_INVADER: begin
            addr_ro  = 1'b1;
            o_prdata = {27'd0, i_invader_x};
         end
         default: begin
            addr_ok = 1'b0;
         end
      endcase
   end

   // No wait states on this bus
   assign o_pready  = 1'b1;
   assign o_pslverr = access & (~addr_ok | (i_pwrite & addr_ro));

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_rst_n) begin
         o_shoot  <= 1'b0;
         o_pause  <= 1'b0;
         o_ship_x <= '0;
      end else begin
         // Shoot is a one-cycle pulse, pause is a held level
         o_shoot <= wr_ctrl & i_pwdata[CTRL_SHOOT_BIT];
         if (wr_ctrl) begin
            o_pause <= i_pwdata[CTRL_PAUSE_BIT];
         end
         if (wr_ship) begin
            o_ship_x <= i_pwdata[4:0];
         end
      end
   end

   // Every APB transfer has a setup cycle, so two shoot writes cannot be adjacent
   assert property (@(posedge i_clk_36MHz) disable iff (!i_rst_n) o_shoot |=> !o_shoot)
      else $error("shoot pulse held for two cycles");

endmodule

`default_nettype wire

// ==== logic/invader.sv ====
// ####################
// Invader motion, hit detection and score counter
// ####################
`timescale 1ns/1ps
`default_nettype none

module invader (
   input  wire                   i_clk_36MHz,
   input  wire                   i_rst_n,
   input  wire                   i_step,
   input  wire                   i_pause,
   input  wire shooter_pkg::col_t i_bullet_x,
   input  wire shooter_pkg::row_t i_bullet_y,
   input  wire                   i_bullet_active,
   output logic                  o_hit,
   output shooter_pkg::col_t      o_invader_x,
   output shooter_pkg::score_t    o_score
);
   import shooter_pkg::*;

   logic match;
   logic hit_event;

   assign match = i_bullet_active
                  && (i_bullet_y == INVADER_ROW)
                  && (i_bullet_x == o_invader_x);

   // While hit is high the bullet is still in flight; a respawn at column 0
   // could match again, so only the first cycle counts
   assign hit_event = match & ~o_hit;

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_rst_n) begin
         o_hit       <= 1'b0;
         o_invader_x <= '0;
         o_score     <= '0;
      end else begin
         o_hit <= hit_event;
         if (hit_event) begin
            o_invader_x <= '0;
            o_score     <= o_score + 1'b1;
         end else if (i_step && !i_pause) begin
            // Column wraps from 31 back to 0
            o_invader_x <= o_invader_x + 1'b1;
         end
      end
   end

   // A hit pulse parks the bullet on the following clock
   assert property (@(posedge i_clk_36MHz) disable iff (!i_rst_n)
                    o_hit |=> !i_bullet_active)
      else $error("bullet still active after hit");

endmodule

`default_nettype wire

// ==== logic/shooter_pkg.sv ====
// ####################
// Playfield geometry, APB register map, coordinate types and bullet FSM states
// ####################
`default_nettype none

package shooter_pkg;

   // Matrix is 32 columns by 16 rows, row 0 at the top
   typedef logic [4:0]  col_t;
   typedef logic [3:0]  row_t;
   typedef logic [7:0]  score_t;

   typedef logic [4:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef enum logic [1:0] {
      BULLET_IDLE   = 2'd0,
      BULLET_LAUNCH = 2'd1,
      BULLET_MOVING = 2'd2
   } bullet_state_t;

   // One step every 2.5 ms at 36 MHz
   localparam int unsigned STEP_CYCLES = 90000;

   // An idle bullet sits below the visible rows
   localparam row_t PARK_ROW    = 4'd14;
   localparam col_t PARK_COL    = 5'd0;
   localparam row_t LAUNCH_ROW  = 4'd12;
   localparam row_t INVADER_ROW = 4'd2;

   localparam apb_addr_t ADDR_CTRL    = 5'h00;
   localparam apb_addr_t ADDR_SHIP    = 5'h04;
   localparam apb_addr_t ADDR_STATUS  = 5'h08;
   localparam apb_addr_t ADDR_SCORE   = 5'h0C;
   localparam apb_addr_t ADDR_INVADER = 5'h10;

   // CTRL bit positions
   localparam int CTRL_SHOOT_BIT = 0;
   localparam int CTRL_PAUSE_BIT = 1;

   // STATUS bit 16 flags a bullet in flight
   localparam int STATUS_ACTIVE_BIT = 16;

endpackage

`default_nettype wire

// ==== logic/shooter_top.sv ====
// ####################
// Top level of the playfield logic
// ####################
`timescale 1ns/1ps
`default_nettype none

module shooter_top #(
   parameter int unsigned STEP_CYCLES = shooter_pkg::STEP_CYCLES
) (
   input  wire                        i_clk_36MHz,
   input  wire                        i_rst_n,
   input  wire                        i_psel,
   input  wire                        i_penable,
   input  wire                        i_pwrite,
   input  wire shooter_pkg::apb_addr_t i_paddr,
   input  wire shooter_pkg::apb_data_t i_pwdata,
   output shooter_pkg::apb_data_t      o_prdata,
   output logic                       o_pready,
   output logic                       o_pslverr
);
   import shooter_pkg::*;

   logic   step;
   logic   shoot;
   logic   pause;
   logic   hit;
   logic   bullet_active;
   col_t   ship_x;
   col_t   bullet_x;
   row_t   bullet_y;
   col_t   invader_x;
   score_t score;

   step_timer #(
      .PERIOD (STEP_CYCLES)
   ) step_timer_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_rst_n     (i_rst_n),
      .o_step      (step)
   );

   game_regs_apb regs_i (
      .i_clk_36MHz     (i_clk_36MHz),
      .i_rst_n         (i_rst_n),
      .i_psel          (i_psel),
      .i_penable       (i_penable),
      .i_pwrite        (i_pwrite),
      .i_paddr         (i_paddr),
      .i_pwdata        (i_pwdata),
      .o_prdata        (o_prdata),
      .o_pready        (o_pready),
      .o_pslverr       (o_pslverr),
      .i_bullet_x      (bullet_x),
      .i_bullet_y      (bullet_y),
      .i_bullet_active (bullet_active),
      .i_invader_x     (invader_x),
      .i_score         (score),
      .o_shoot         (shoot),
      .o_pause         (pause),
      .o_ship_x        (ship_x)
   );

   bullet bullet_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_rst_n     (i_rst_n),
      .i_shoot     (shoot),
      .i_hit       (hit),
      .i_step      (step),
      .i_ship_x    (ship_x),
      .o_bullet_x  (bullet_x),
      .o_bullet_y  (bullet_y),
      .o_active    (bullet_active)
   );

   invader invader_i (
      .i_clk_36MHz     (i_clk_36MHz),
      .i_rst_n         (i_rst_n),
      .i_step          (step),
      .i_pause         (pause),
      .i_bullet_x      (bullet_x),
      .i_bullet_y      (bullet_y),
      .i_bullet_active (bullet_active),
      .o_hit           (hit),
      .o_invader_x     (invader_x),
      .o_score         (score)
   );

endmodule

`default_nettype wire

// ==== logic/step_timer.sv ====
// ####################
// Game step divider
// ####################
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
   parameter int unsigned PERIOD = shooter_pkg::STEP_CYCLES
) (
   input  wire  i_clk_36MHz,
   input  wire  i_rst_n,
   output logic o_step
);

   localparam int unsigned CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

   logic [CNT_W-1:0] count;
   logic             wrap;

   assign wrap = (count == CNT_W'(PERIOD - 1));

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_rst_n) begin
         count  <= '0;
         o_step <= 1'b0;
      end else begin
         count  <= wrap ? '0 : count + 1'b1;
         o_step <= wrap;
      end
   end

   if (PERIOD > 1) begin : g_step_check
      assert property (@(posedge i_clk_36MHz) disable iff (!i_rst_n) o_step |=> !o_step)
         else $error("step pulse lasted more than one cycle");
   end

endmodule

`default_nettype wire

// ==== shooter_top.f ====
logic/shooter_pkg.sv
logic/step_timer.sv
logic/game_regs_apb.sv
logic/bullet.sv
logic/invader.sv
logic/shooter_top.sv
bench/shooter_tb.sv
